// ==== rtl/imgproc_pkg.sv ====
// fixed 640x480 rgb888 geometry; thresholds are tuned for the camera lighting and are not runtime settable
package imgproc_pkg;

	//////////////////////////////
	// frame geometry
	//////////////////////////////
	localparam int IMAGE_W = 640;
	localparam int IMAGE_H = 480;
	localparam int COORD_W = 11;
	// pixels this close to any edge are never classified
	localparam int BORDER = 20;

	//////////////////////////////
	// colour classes
	//////////////////////////////
	localparam int NUM_COLOURS = 5;
	localparam int CLASS_W = 3;
	localparam logic [CLASS_W-1:0] CLS_RED = 3'd0;
	localparam logic [CLASS_W-1:0] CLS_GREEN = 3'd1;
	localparam logic [CLASS_W-1:0] CLS_BLUE = 3'd2;
	localparam logic [CLASS_W-1:0] CLS_VIOLET = 3'd3;
	localparam logic [CLASS_W-1:0] CLS_YELLOW = 3'd4;
	localparam logic [CLASS_W-1:0] CLS_NONE = 3'd7;

	// hsv limits, all inclusive; hue is the halved 0..179 scale
	// red hue wraps: at or above RED_H_HI, or at or below RED_H_LO
	localparam logic [7:0] RED_H_HI = 8'd171;
	localparam logic [7:0] RED_H_LO = 8'd24;
	localparam logic [7:0] RED_S_LO = 8'd150;
	localparam logic [7:0] RED_S_HI = 8'd231;
	localparam logic [7:0] RED_V_LO = 8'd126;
	localparam logic [7:0] RED_V_HI = 8'd200;
	localparam logic [7:0] GREEN_H_LO = 8'd61;
	localparam logic [7:0] GREEN_H_HI = 8'd79;
	localparam logic [7:0] GREEN_S_LO = 8'd76;
	localparam logic [7:0] GREEN_S_HI = 8'd199;
	localparam logic [7:0] GREEN_V_LO = 8'd51;
	localparam logic [7:0] GREEN_V_HI = 8'd127;
	localparam logic [7:0] BLUE_H_LO = 8'd91;
	localparam logic [7:0] BLUE_H_HI = 8'd119;
	localparam logic [7:0] BLUE_S_LO = 8'd77;
	localparam logic [7:0] BLUE_S_HI = 8'd194;
	localparam logic [7:0] BLUE_V_LO = 8'd26;
	localparam logic [7:0] BLUE_V_HI = 8'd127;
	// violet has only an upper hue limit
	localparam logic [7:0] VIOLET_H_HI = 8'd14;
	localparam logic [7:0] VIOLET_S_LO = 8'd81;
	localparam logic [7:0] VIOLET_S_HI = 8'd149;
	localparam logic [7:0] VIOLET_V_LO = 8'd76;
	localparam logic [7:0] VIOLET_V_HI = 8'd125;
	localparam logic [7:0] YELLOW_H_LO = 8'd26;
	localparam logic [7:0] YELLOW_H_HI = 8'd44;
	localparam logic [7:0] YELLOW_S_LO = 8'd101;
	localparam logic [7:0] YELLOW_S_HI = 8'd152;
	localparam logic [7:0] YELLOW_V_LO = 8'd103;
	localparam logic [7:0] YELLOW_V_HI = 8'd245;

	//////////////////////////////
	// stream types
	//////////////////////////////
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	typedef struct packed {
		pixel_t pix;
		logic sop;
		logic eop;
	} beat_t;

	typedef struct packed {
		logic [COORD_W-1:0] xmin;
		logic [COORD_W-1:0] xmax;
		logic [COORD_W-1:0] ymin;
		logic [COORD_W-1:0] ymax;
	} bbox_t;

	// empty box, xmin above xmax marks the colour as unseen
	localparam bbox_t BOX_RESET = '{
		xmin: COORD_W'(IMAGE_W - 1),
		xmax: '0,
		ymin: COORD_W'(IMAGE_H - 1),
		ymax: '0
	};

	// overlay colours, indexed by class
	localparam pixel_t HIGHLIGHT [NUM_COLOURS] = '{
		24'hff0001, 24'h00ff00, 24'h0000ff, 24'h8e1596, 24'hedff6f
	};
	localparam pixel_t BOX_COLOUR [NUM_COLOURS] = '{
		24'hff7575, 24'h92ff96, 24'h92eeff, 24'hff92ea, 24'hf9ff92
	};
	localparam pixel_t BACKGROUND = 24'h0;

	//////////////////////////////
	// messages and cpu port
	//////////////////////////////
	localparam int MSG_INTERVAL = 6;
	localparam int MSG_CNT_W = $clog2(MSG_INTERVAL);
	localparam int MSG_WORDS = 15;
	localparam int FIFO_DEPTH = 256;
	localparam int FIFO_AW = 8;
	localparam logic [23:0] MSG_ID [NUM_COLOURS] = '{"RBB", "GBB", "BBB", "VBB", "YBB"};

	localparam logic [2:0] ADDR_STATUS = 3'd0;
	localparam logic [2:0] ADDR_MSG = 3'd1;
	localparam logic [2:0] ADDR_ID = 3'd2;
	localparam logic [31:0] DEVICE_ID = 32'h1234EEE2;
	localparam int FLUSH_BIT = 4;

	typedef struct packed {
		logic [7:0] pad;
		logic [23:0] ascii;
	} msg_id_t;

	typedef struct packed {
		logic [4:0] pad_x;
		logic [COORD_W-1:0] x;
		logic [4:0] pad_y;
		logic [COORD_W-1:0] y;
	} msg_corner_t;

	// a message word is either a box id or a corner coordinate
	typedef union packed {
		msg_id_t id;
		msg_corner_t corner;
	} msg_word_u;

endpackage

// ==== rtl/stream_reg.sv ====
// one beat deep, so a stalled sink sees ready drop in the same cycle as the downstream stall
`timescale 1ns/100ps

module stream_reg (
	input  logic clk,
	input  logic reset_n,
	input  logic valid_in,
	input  imgproc_pkg::beat_t beat_in,
	output logic ready_out,
	output logic valid_out,
	output imgproc_pkg::beat_t beat_out,
	input  logic ready_in
);

	// room when empty or when the held beat leaves this cycle
	assign ready_out = ~valid_out | ready_in;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	// payload only, holds while stalled
	always_ff @(posedge clk) begin
		if (ready_out && valid_in) begin
			beat_out <= beat_in;
		end
	end

endmodule

// ==== rtl/pixel_coord.sv ====
// coordinates are undefined until the first sop beat; the sop header itself has no position
`timescale 1ns/100ps

module pixel_coord (
	input  logic clk,
	input  logic fire,
	input  logic sop,
	input  logic [3:0] blue_nibble,
	output logic [imgproc_pkg::COORD_W-1:0] x,
	output logic [imgproc_pkg::COORD_W-1:0] y,
	output logic is_video
);

	// x, y always name the beat now waiting in the input register
	always_ff @(posedge clk) begin
		if (fire) begin
			if (sop) begin
				x <= '0;
				y <= '0;
				// header word with blue low nibble zero marks a video packet
				is_video <= (blue_nibble == 4'h0);
			end else if (x == imgproc_pkg::COORD_W'(imgproc_pkg::IMAGE_W - 1)) begin
				// end of row
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/hsv_classifier.sv ====
// purely combinational divide path; the first matching colour wins, border pixels are always none
`timescale 1ns/100ps

module hsv_classifier (
	input  imgproc_pkg::pixel_t pix,
	input  logic [imgproc_pkg::COORD_W-1:0] x,
	input  logic [imgproc_pkg::COORD_W-1:0] y,
	output logic [imgproc_pkg::CLASS_W-1:0] cls
);

	logic [7:0] v_max;
	logic [7:0] v_min;
	logic [7:0] diff;
	logic [15:0] sat_full;
	logic [7:0] sat;
	logic [7:0] hue;
	int hue_base;
	int hue_delta;
	int hue_full;
	logic border;
	logic red_hit;
	logic green_hit;
	logic blue_hit;
	logic violet_hit;
	logic yellow_hit;

	function automatic logic in_range(input logic [7:0] val, input logic [7:0] lo,
		input logic [7:0] hi);
		return (val >= lo) && (val <= hi);
	endfunction

	//////////////////////////////
	// rgb to hsv
	//////////////////////////////
	always_comb begin
		// value is the largest channel
		v_max = pix.r;
		if (pix.g > v_max) v_max = pix.g;
		if (pix.b > v_max) v_max = pix.b;
		v_min = pix.r;
		if (pix.g < v_min) v_min = pix.g;
		if (pix.b < v_min) v_min = pix.b;
		diff = v_max - v_min;
		// saturation scaled to 0..255
		sat_full = (v_max == 8'd0) ? 16'd0 : (16'd255 * diff) / v_max;
		sat = sat_full[7:0];
		// opencv hue in degrees, numerator kept positive so truncation is a floor
		if (diff == 8'd0) begin
			hue_base = 0;
			hue_delta = 0;
		end else if (v_max == pix.r) begin
			hue_base = (pix.g >= pix.b) ? 0 : 360;
			hue_delta = int'(pix.g) - int'(pix.b);
		end else if (v_max == pix.g) begin
			hue_base = 120;
			hue_delta = int'(pix.b) - int'(pix.r);
		end else begin
			hue_base = 240;
			hue_delta = int'(pix.r) - int'(pix.g);
		end
		hue_full = (diff == 8'd0) ? 0 : (hue_base * int'(diff) + 60 * hue_delta) / int'(diff);
		// halved to fit a byte
		hue = 8'(hue_full / 2);
	end

	//////////////////////////////
	// threshold tests
	//////////////////////////////
	assign border = (x <= imgproc_pkg::BORDER) ||
		(x >= imgproc_pkg::IMAGE_W - imgproc_pkg::BORDER) ||
		(y <= imgproc_pkg::BORDER) ||
		(y >= imgproc_pkg::IMAGE_H - imgproc_pkg::BORDER);

	// red hue wraps around zero
	assign red_hit = ((hue >= imgproc_pkg::RED_H_HI) || (hue <= imgproc_pkg::RED_H_LO)) &&
		in_range(sat, imgproc_pkg::RED_S_LO, imgproc_pkg::RED_S_HI) &&
		in_range(v_max, imgproc_pkg::RED_V_LO, imgproc_pkg::RED_V_HI);
	assign green_hit = in_range(hue, imgproc_pkg::GREEN_H_LO, imgproc_pkg::GREEN_H_HI) &&
		in_range(sat, imgproc_pkg::GREEN_S_LO, imgproc_pkg::GREEN_S_HI) &&
		in_range(v_max, imgproc_pkg::GREEN_V_LO, imgproc_pkg::GREEN_V_HI);
	assign blue_hit = in_range(hue, imgproc_pkg::BLUE_H_LO, imgproc_pkg::BLUE_H_HI) &&
		in_range(sat, imgproc_pkg::BLUE_S_LO, imgproc_pkg::BLUE_S_HI) &&
		in_range(v_max, imgproc_pkg::BLUE_V_LO, imgproc_pkg::BLUE_V_HI);
	assign violet_hit = (hue <= imgproc_pkg::VIOLET_H_HI) &&
		in_range(sat, imgproc_pkg::VIOLET_S_LO, imgproc_pkg::VIOLET_S_HI) &&
		in_range(v_max, imgproc_pkg::VIOLET_V_LO, imgproc_pkg::VIOLET_V_HI);
	assign yellow_hit = in_range(hue, imgproc_pkg::YELLOW_H_LO, imgproc_pkg::YELLOW_H_HI) &&
		in_range(sat, imgproc_pkg::YELLOW_S_LO, imgproc_pkg::YELLOW_S_HI) &&
		in_range(v_max, imgproc_pkg::YELLOW_V_LO, imgproc_pkg::YELLOW_V_HI);

	// priority red, green, blue, violet, yellow
	always_comb begin
		if (border) cls = imgproc_pkg::CLS_NONE;
		else if (red_hit) cls = imgproc_pkg::CLS_RED;
		else if (green_hit) cls = imgproc_pkg::CLS_GREEN;
		else if (blue_hit) cls = imgproc_pkg::CLS_BLUE;
		else if (violet_hit) cls = imgproc_pkg::CLS_VIOLET;
		else if (yellow_hit) cls = imgproc_pkg::CLS_YELLOW;
		else cls = imgproc_pkg::CLS_NONE;
	end

endmodule

// ==== rtl/bbox_tracker.sv ====
// one box per colour; edges are drawn as full rows and columns, from the previous video frame only
`timescale 1ns/100ps

module bbox_tracker (
	input  logic clk,
	input  logic reset_n,
	input  logic fire,
	input  logic sop,
	input  logic eop,
	input  logic is_video,
	input  logic [imgproc_pkg::COORD_W-1:0] x,
	input  logic [imgproc_pkg::COORD_W-1:0] y,
	input  logic [imgproc_pkg::CLASS_W-1:0] cls,
	output imgproc_pkg::bbox_t [imgproc_pkg::NUM_COLOURS-1:0] boxes,
	output logic end_of_frame,
	output logic edge_hit,
	output logic [imgproc_pkg::CLASS_W-1:0] edge_cls
);

	// extents of the frame in flight
	imgproc_pkg::bbox_t [imgproc_pkg::NUM_COLOURS-1:0] run;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int c = 0; c < imgproc_pkg::NUM_COLOURS; c++) begin
				run[c] <= imgproc_pkg::BOX_RESET;
				boxes[c] <= imgproc_pkg::BOX_RESET;
			end
			end_of_frame <= 1'b0;
		end else begin
			// one cycle pulse, boxes are already latched when it is seen
			end_of_frame <= fire & ~sop & eop & is_video;
			if (fire && sop) begin
				for (int c = 0; c < imgproc_pkg::NUM_COLOURS; c++) begin
					run[c] <= imgproc_pkg::BOX_RESET;
				end
			end else if (fire) begin
				// grow the box of this pixel's class
				for (int c = 0; c < imgproc_pkg::NUM_COLOURS; c++) begin
					if (cls == c) begin
						if (x < run[c].xmin) run[c].xmin <= x;
						if (x > run[c].xmax) run[c].xmax <= x;
						if (y < run[c].ymin) run[c].ymin <= y;
						if (y > run[c].ymax) run[c].ymax <= y;
					end
				end
				// non-video packets never touch the latched boxes
				if (eop && is_video) begin
					boxes <= run;
				end
			end
		end
	end

	//////////////////////////////
	// edge overlay
	//////////////////////////////
	// scan downward so the lowest class index wins
	always_comb begin
		edge_hit = 1'b0;
		edge_cls = imgproc_pkg::CLS_NONE;
		for (int c = imgproc_pkg::NUM_COLOURS - 1; c >= 0; c--) begin
			// skip colours that were not seen
			if ((boxes[c].xmin <= boxes[c].xmax) &&
				((x == boxes[c].xmin) || (x == boxes[c].xmax) ||
				(y == boxes[c].ymin) || (y == boxes[c].ymax))) begin
				edge_hit = 1'b1;
				edge_cls = imgproc_pkg::CLASS_W'(c);
			end
		end
	end

endmodule

// ==== rtl/msg_writer.sv ====
// writes a full fifteen-word set or nothing; a frame with too little FIFO room retries on the next frame
`timescale 1ns/100ps

module msg_writer (
	input  logic clk,
	input  logic reset_n,
	input  logic end_of_frame,
	input  imgproc_pkg::bbox_t [imgproc_pkg::NUM_COLOURS-1:0] boxes,
	input  logic [imgproc_pkg::FIFO_AW:0] fifo_used,
	output logic wr,
	output imgproc_pkg::msg_word_u wr_word
);

	logic [imgproc_pkg::MSG_CNT_W-1:0] frame_cnt;
	// colour being sent and word within it (id, top left, bottom right)
	logic [imgproc_pkg::CLASS_W-1:0] col;
	logic [1:0] part;
	logic room;

	assign room = fifo_used < (imgproc_pkg::FIFO_DEPTH - imgproc_pkg::MSG_WORDS);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			wr <= 1'b0;
			col <= '0;
			part <= '0;
		end else begin
			if (end_of_frame) begin
				if (frame_cnt == '0 && room) begin
					frame_cnt <= imgproc_pkg::MSG_CNT_W'(imgproc_pkg::MSG_INTERVAL - 1);
					wr <= 1'b1;
					col <= '0;
					part <= '0;
				end else if (frame_cnt != '0) begin
					frame_cnt <= frame_cnt - 1'b1;
				end
			end
			// step through the words, one per cycle
			if (wr && !end_of_frame) begin
				if (part == 2'd2) begin
					part <= 2'd0;
					col <= col + 1'b1;
					if (col == imgproc_pkg::CLS_YELLOW) wr <= 1'b0;
				end else begin
					part <= part + 1'b1;
				end
			end
		end
	end

	// pad bits stay zero
	always_comb begin
		wr_word = '0;
		case (part)
			2'd0: wr_word.id.ascii = imgproc_pkg::MSG_ID[col];
			2'd1: begin
				wr_word.corner.x = boxes[col].xmin;
				wr_word.corner.y = boxes[col].ymin;
			end
			default: begin
				wr_word.corner.x = boxes[col].xmax;
				wr_word.corner.y = boxes[col].ymax;
			end
		endcase
	end

endmodule

// ==== rtl/msg_fifo.sv ====
// first word falls through; writes into a full FIFO and reads from an empty one are dropped
`timescale 1ns/100ps

module msg_fifo (
	input  logic clk,
	input  logic reset_n,
	input  logic clear,
	input  logic wr,
	input  logic [31:0] wr_data,
	input  logic rd,
	output logic [31:0] rd_data,
	output logic [imgproc_pkg::FIFO_AW:0] used,
	output logic empty
);

	logic [31:0] mem [imgproc_pkg::FIFO_DEPTH];
	logic [imgproc_pkg::FIFO_AW-1:0] wr_ptr;
	logic [imgproc_pkg::FIFO_AW-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign empty = (used == '0);
	assign do_wr = wr && (used != imgproc_pkg::FIFO_DEPTH);
	assign do_rd = rd && !empty;
	// head word is visible without a read
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (do_wr && !do_rd) used <= used + 1'b1;
			else if (do_rd && !do_wr) used <= used - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) mem[wr_ptr] <= wr_data;
	end

endmodule

// ==== rtl/mm_regs.sv ====
// read data lags the strobe by one cycle; a held message read pops only once
`timescale 1ns/100ps

module mm_regs (
	input  logic clk,
	input  logic reset_n,
	input  logic s_chipselect,
	input  logic s_read,
	input  logic s_write,
	input  logic [2:0] s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata,
	input  logic [31:0] fifo_data,
	input  logic [imgproc_pkg::FIFO_AW:0] fifo_used,
	input  logic fifo_empty,
	output logic fifo_rd,
	output logic fifo_clear
);

	logic [7:0] status;
	logic read_d;
	logic [7:0] used_byte;
	logic status_wr;

	// a full FIFO would not fit the byte, so it reads as ff
	assign used_byte = fifo_used[imgproc_pkg::FIFO_AW] ? 8'hff :
		fifo_used[imgproc_pkg::FIFO_AW-1:0];
	assign status_wr = s_chipselect & s_write & (s_address == imgproc_pkg::ADDR_STATUS);

	// flush rides on a status write
	assign fifo_clear = status_wr & s_writedata[imgproc_pkg::FLUSH_BIT];
	// pop on the first cycle of a message read only
	assign fifo_rd = s_chipselect & s_read & ~read_d & ~fifo_empty &
		(s_address == imgproc_pkg::ADDR_MSG);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status <= 8'h0;
			read_d <= 1'b0;
			s_readdata <= 32'h0;
		end else begin
			read_d <= s_chipselect & s_read;
			if (status_wr) status <= s_writedata[7:0];
			if (s_chipselect && s_read) begin
				case (s_address)
					imgproc_pkg::ADDR_STATUS: s_readdata <= {16'h0, used_byte, status};
					imgproc_pkg::ADDR_MSG: s_readdata <= fifo_data;
					imgproc_pkg::ADDR_ID: s_readdata <= imgproc_pkg::DEVICE_ID;
					default: s_readdata <= 32'h0;
				endcase
			end
		end
	end

endmodule

// ==== rtl/eee_imgproc.sv ====
// two-register stream path; overlay needs mode held steady across a frame, sop headers pass unchanged
`timescale 1ns/100ps

module eee_imgproc (
	input  logic clk,
	input  logic reset_n,
	// cpu port
	input  logic s_chipselect,
	input  logic s_read,
	input  logic s_write,
	input  logic [2:0] s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata,
	// video in
	input  logic [23:0] sink_data,
	input  logic sink_valid,
	output logic sink_ready,
	input  logic sink_sop,
	input  logic sink_eop,
	// video out
	output logic [23:0] source_data,
	output logic source_valid,
	input  logic source_ready,
	output logic source_sop,
	output logic source_eop,
	input  logic mode
);

	imgproc_pkg::beat_t sink_beat;
	imgproc_pkg::beat_t in_beat;
	imgproc_pkg::beat_t out_beat;
	imgproc_pkg::beat_t source_beat;
	logic in_valid;
	logic out_ready;
	logic in_fire;
	logic [imgproc_pkg::COORD_W-1:0] x;
	logic [imgproc_pkg::COORD_W-1:0] y;
	logic is_video;
	logic [imgproc_pkg::CLASS_W-1:0] cls;
	imgproc_pkg::bbox_t [imgproc_pkg::NUM_COLOURS-1:0] boxes;
	logic end_of_frame;
	logic edge_hit;
	logic [imgproc_pkg::CLASS_W-1:0] edge_cls;
	logic fifo_wr;
	imgproc_pkg::msg_word_u fifo_wr_word;
	logic [31:0] fifo_rd_data;
	logic [imgproc_pkg::FIFO_AW:0] fifo_used;
	logic fifo_empty;
	logic fifo_rd;
	logic fifo_clear;

	//////////////////////////////
	// stream path
	//////////////////////////////
	assign sink_beat = {sink_data, sink_sop, sink_eop};
	assign {source_data, source_sop, source_eop} = source_beat;
	// beat moves from input to output register
	assign in_fire = in_valid & out_ready;

	stream_reg in_reg (
		.clk(clk), .reset_n(reset_n),
		.valid_in(sink_valid), .beat_in(sink_beat), .ready_out(sink_ready),
		.valid_out(in_valid), .beat_out(in_beat), .ready_in(out_ready)
	);

	// edge beats the class colour, class beats background
	always_comb begin
		out_beat = in_beat;
		if (mode && !in_beat.sop && is_video) begin
			if (edge_hit) out_beat.pix = imgproc_pkg::BOX_COLOUR[edge_cls];
			else if (cls != imgproc_pkg::CLS_NONE) out_beat.pix = imgproc_pkg::HIGHLIGHT[cls];
			else out_beat.pix = imgproc_pkg::BACKGROUND;
		end
	end

	stream_reg out_reg (
		.clk(clk), .reset_n(reset_n),
		.valid_in(in_valid), .beat_in(out_beat), .ready_out(out_ready),
		.valid_out(source_valid), .beat_out(source_beat), .ready_in(source_ready)
	);

	//////////////////////////////
	// detection
	//////////////////////////////
	pixel_coord pixel_coord_inst (
		.clk(clk), .fire(in_fire), .sop(in_beat.sop), .blue_nibble(in_beat.pix.b[3:0]),
		.x(x), .y(y), .is_video(is_video)
	);

	hsv_classifier hsv_classifier_inst (.pix(in_beat.pix), .x(x), .y(y), .cls(cls));

	bbox_tracker bbox_tracker_inst (
		.clk(clk), .reset_n(reset_n), .fire(in_fire),
		.sop(in_beat.sop), .eop(in_beat.eop), .is_video(is_video),
		.x(x), .y(y), .cls(cls), .boxes(boxes), .end_of_frame(end_of_frame),
		.edge_hit(edge_hit), .edge_cls(edge_cls)
	);

	//////////////////////////////
	// messages and cpu port
	//////////////////////////////
	msg_writer msg_writer_inst (
		.clk(clk), .reset_n(reset_n), .end_of_frame(end_of_frame), .boxes(boxes),
		.fifo_used(fifo_used), .wr(fifo_wr), .wr_word(fifo_wr_word)
	);

	msg_fifo msg_fifo_inst (
		.clk(clk), .reset_n(reset_n), .clear(fifo_clear),
		.wr(fifo_wr), .wr_data(fifo_wr_word), .rd(fifo_rd),
		.rd_data(fifo_rd_data), .used(fifo_used), .empty(fifo_empty)
	);

	mm_regs mm_regs_inst (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.fifo_data(fifo_rd_data), .fifo_used(fifo_used), .fifo_empty(fifo_empty),
		.fifo_rd(fifo_rd), .fifo_clear(fifo_clear)
	);

endmodule

// ==== sim/eee_imgproc_tb.sv ====
// full 640x480 frames, a few million cycles per run; each rectangle must sit clear of the border
`timescale 1ns/100ps

module eee_imgproc_tb;

	// one table row: mode, video flag, background, rectangle and its pixel, class, message words
	typedef struct packed {
		logic mode;
		logic video;
		imgproc_pkg::pixel_t bg;
		logic [imgproc_pkg::COORD_W-1:0] x0;
		logic [imgproc_pkg::COORD_W-1:0] x1;
		logic [imgproc_pkg::COORD_W-1:0] y0;
		logic [imgproc_pkg::COORD_W-1:0] y1;
		imgproc_pkg::pixel_t pix;
		logic [imgproc_pkg::CLASS_W-1:0] cls;
		logic [7:0] msgs;
	} test_t;

	logic clk;
	logic reset_n;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata;
	logic [31:0] s_readdata;
	logic [23:0] sink_data;
	logic sink_valid;
	logic sink_ready;
	logic sink_sop;
	logic sink_eop;
	logic [23:0] source_data;
	logic source_valid;
	logic source_ready;
	logic source_sop;
	logic source_eop;
	logic mode;

	integer seed;
	int errors;
	int cycles;
	int cycle_limit;
	string cur_name;
	string test_name [5];
	test_t tests [5];
	logic [31:0] rd_word;
	imgproc_pkg::beat_t want_beat;
	// beats the source must produce, oldest first
	imgproc_pkg::beat_t expq [$];
	// model extents: frame in flight and latched at the last video eop
	imgproc_pkg::bbox_t run_box [imgproc_pkg::NUM_COLOURS];
	imgproc_pkg::bbox_t held_box [imgproc_pkg::NUM_COLOURS];

	eee_imgproc eee_imgproc_inst (.*);

	always #10 clk = ~clk;

	//////////////////////////////
	// timeout and stream monitor
	//////////////////////////////
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// random downstream stalls
	always @(negedge clk) begin
		if (reset_n) source_ready = ($random(seed) & 3) != 0;
	end

	always @(posedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			assert (expq.size() != 0) else begin
				errors++;
				$display("%s: source gave a beat when none was expected", cur_name);
			end
			if (expq.size() != 0) begin
				want_beat = expq.pop_front();
				check_value(cur_name, 32'(want_beat), 32'({source_data, source_sop, source_eop}));
			end
		end
	end

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", what, exp, got);
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic imgproc_pkg::bbox_t unseen_box();
		return {11'(imgproc_pkg::IMAGE_W - 1), 11'd0, 11'(imgproc_pkg::IMAGE_H - 1), 11'd0};
	endfunction

	// rectangle pixels take the table class, border and background none
	function automatic logic [2:0] pixel_class(input int t, input int x, input int y);
		logic border;
		border = (x <= imgproc_pkg::BORDER) || (x >= imgproc_pkg::IMAGE_W - imgproc_pkg::BORDER) ||
			(y <= imgproc_pkg::BORDER) || (y >= imgproc_pkg::IMAGE_H - imgproc_pkg::BORDER);
		if (!border && x >= tests[t].x0 && x <= tests[t].x1 && y >= tests[t].y0 && y <= tests[t].y1)
			return tests[t].cls;
		return imgproc_pkg::CLS_NONE;
	endfunction

	function automatic imgproc_pkg::pixel_t overlay_pixel(input int t, input int x, input int y,
		input imgproc_pkg::pixel_t in_pix);
		logic [2:0] c;
		int k;
		c = pixel_class(t, x, y);
		if (!(tests[t].mode && tests[t].video)) return in_pix;
		// edges of seen boxes first, lowest class wins
		for (k = 0; k < imgproc_pkg::NUM_COLOURS; k++) begin
			if (held_box[k].xmin <= held_box[k].xmax &&
				(x == held_box[k].xmin || x == held_box[k].xmax ||
				y == held_box[k].ymin || y == held_box[k].ymax))
				return imgproc_pkg::BOX_COLOUR[k];
		end
		if (c != imgproc_pkg::CLS_NONE) return imgproc_pkg::HIGHLIGHT[c];
		return imgproc_pkg::BACKGROUND;
	endfunction

	task automatic track_pixel(input int t, input int x, input int y);
		logic [2:0] c;
		c = pixel_class(t, x, y);
		if (c != imgproc_pkg::CLS_NONE) begin
			if (x < run_box[c].xmin) run_box[c].xmin = x;
			if (x > run_box[c].xmax) run_box[c].xmax = x;
			if (y < run_box[c].ymin) run_box[c].ymin = y;
			if (y > run_box[c].ymax) run_box[c].ymax = y;
		end
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////
	// random valid gaps, then hold the beat until the sink takes it
	task automatic send_beat(input imgproc_pkg::beat_t b);
		while (($random(seed) & 7) == 0) begin
			sink_valid = 1'b0;
			@(negedge clk);
		end
		sink_valid = 1'b1;
		{sink_data, sink_sop, sink_eop} = b;
		@(posedge clk);
		while (!sink_ready) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic run_frame(input int t);
		imgproc_pkg::beat_t b;
		int x;
		int y;
		int k;
		cur_name = test_name[t];
		mode = tests[t].mode;
		for (k = 0; k < imgproc_pkg::NUM_COLOURS; k++) run_box[k] = unseen_box();
		// header word, blue low nibble zero means video
		b = {16'h0, tests[t].video ? 8'h00 : 8'h0f, 1'b1, 1'b0};
		expq.push_back(b);
		send_beat(b);
		for (int i = 0; i < imgproc_pkg::IMAGE_W * imgproc_pkg::IMAGE_H; i++) begin
			x = i % imgproc_pkg::IMAGE_W;
			y = i / imgproc_pkg::IMAGE_W;
			b.pix = (pixel_class(t, x, y) != imgproc_pkg::CLS_NONE) ? tests[t].pix : tests[t].bg;
			b.sop = 1'b0;
			b.eop = (i == imgproc_pkg::IMAGE_W * imgproc_pkg::IMAGE_H - 1);
			expq.push_back({overlay_pixel(t, x, y, b.pix), b.sop, b.eop});
			track_pixel(t, x, y);
			send_beat(b);
		end
		sink_valid = 1'b0;
		if (tests[t].video) begin
			for (k = 0; k < imgproc_pkg::NUM_COLOURS; k++) held_box[k] = run_box[k];
		end
		while (expq.size() != 0) @(negedge clk);
		// message words follow the frame end on consecutive cycles
		repeat (imgproc_pkg::MSG_WORDS + 4) @(negedge clk);
	endtask

	//////////////////////////////
	// cpu port
	//////////////////////////////
	// data lands one cycle after the strobe, idle cycle so the next read pops again
	task automatic cpu_read(input logic [2:0] addr, output logic [31:0] data);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_read = 1'b0;
		data = s_readdata;
		@(negedge clk);
	endtask

	task automatic cpu_write(input logic [2:0] addr, input logic [31:0] data);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	task automatic check_messages(input int t);
		logic [31:0] rd;
		cpu_read(imgproc_pkg::ADDR_STATUS, rd);
		check_value({cur_name, " used words"}, 32'(tests[t].msgs), 32'(rd[15:8]));
		if (tests[t].msgs == imgproc_pkg::MSG_WORDS) begin
			// yellow words stay queued so the flush has something to drop
			for (int c = 0; c < imgproc_pkg::NUM_COLOURS - 1; c++) begin
				cpu_read(imgproc_pkg::ADDR_MSG, rd);
				check_value({cur_name, " msg id"}, {8'h0, imgproc_pkg::MSG_ID[c]}, rd);
				cpu_read(imgproc_pkg::ADDR_MSG, rd);
				check_value({cur_name, " msg min"},
					{5'h0, held_box[c].xmin, 5'h0, held_box[c].ymin}, rd);
				cpu_read(imgproc_pkg::ADDR_MSG, rd);
				check_value({cur_name, " msg max"},
					{5'h0, held_box[c].xmax, 5'h0, held_box[c].ymax}, rd);
			end
			cpu_read(imgproc_pkg::ADDR_STATUS, rd);
			check_value({cur_name, " words left"}, 32'd3, 32'(rd[15:8]));
			// 3c has the flush bit set
			cpu_write(imgproc_pkg::ADDR_STATUS, 32'h3c);
			cpu_read(imgproc_pkg::ADDR_STATUS, rd);
			check_value({cur_name, " after flush"}, 32'h0000003c, rd);
		end
	endtask

	initial begin
		seed = 32'hfdb6788d;
		errors = 0;
		cycles = 0;
		clk = 1'b0;
		reset_n = 1'b0;
		{s_chipselect, s_read, s_write, s_address, s_writedata} = '0;
		{sink_data, sink_valid, sink_sop, sink_eop} = '0;
		source_ready = 1'b0;
		mode = 1'b0;
		// mode, video, background, x0, x1, y0, y1, rectangle pixel, class, message words
		test_name[0] = "bypass_green";
		tests[0] = {1'b0, 1'b1, 24'h808080, 11'd100, 11'd199, 11'd60, 11'd139,
			24'h28783c, imgproc_pkg::CLS_GREEN, 8'd15};
		test_name[1] = "highlight_red";
		tests[1] = {1'b1, 1'b1, 24'h808080, 11'd300, 11'd379, 11'd200, 11'd259,
			24'hc83c3c, imgproc_pkg::CLS_RED, 8'd0};
		test_name[2] = "nonvideo_violet";
		tests[2] = {1'b1, 1'b0, 24'h808080, 11'd50, 11'd149, 11'd300, 11'd399,
			24'h78463c, imgproc_pkg::CLS_VIOLET, 8'd0};
		test_name[3] = "edges_blue";
		tests[3] = {1'b1, 1'b1, 24'h808080, 11'd400, 11'd519, 11'd100, 11'd179,
			24'h1e3c78, imgproc_pkg::CLS_BLUE, 8'd0};
		test_name[4] = "edges_yellow";
		tests[4] = {1'b1, 1'b1, 24'h808080, 11'd200, 11'd299, 11'd300, 11'd419,
			24'hc8c864, imgproc_pkg::CLS_YELLOW, 8'd0};
		cycle_limit = ($size(tests) + 1) * imgproc_pkg::IMAGE_W * imgproc_pkg::IMAGE_H * 3;
		for (int k = 0; k < imgproc_pkg::NUM_COLOURS; k++) held_box[k] = unseen_box();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		assert (sink_ready === 1'b1 && source_valid === 1'b0 && s_readdata === 32'h0) else begin
			errors++;
			$display("after reset the stream or cpu port outputs were not at their reset values");
		end
		for (int t = 0; t < $size(tests); t++) begin
			run_frame(t);
			check_messages(t);
		end
		cur_name = "device_id";
		cpu_read(imgproc_pkg::ADDR_ID, rd_word);
		check_value(cur_name, imgproc_pkg::DEVICE_ID, rd_word);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== eee_imgproc.f ====
rtl/imgproc_pkg.sv
rtl/stream_reg.sv
rtl/pixel_coord.sv
rtl/hsv_classifier.sv
rtl/bbox_tracker.sv
rtl/msg_writer.sv
rtl/msg_fifo.sv
rtl/mm_regs.sv
rtl/eee_imgproc.sv
sim/eee_imgproc_tb.sv

// ==== Bender.yml ====
package:
  name: eee_imgproc

sources:
  - rtl/imgproc_pkg.sv
  - rtl/stream_reg.sv
  - rtl/pixel_coord.sv
  - rtl/hsv_classifier.sv
  - rtl/bbox_tracker.sv
  - rtl/msg_writer.sv
  - rtl/msg_fifo.sv
  - rtl/mm_regs.sv
  - rtl/eee_imgproc.sv
  - target: simulation
    files:
      - sim/eee_imgproc_tb.sv
